// File: hdl/paint_pkg.sv
package paint_pkg;

    // Screen geometry
    localparam int SCREEN_WIDTH  = 320;
    localparam int SCREEN_HEIGHT = 240;

    // Coordinate and data widths
    typedef logic [8:0] coord_x_t;
    typedef logic [7:0] coord_y_t;
    typedef logic [8:0] color_t;
    typedef logic [7:0] mouse_delta_t;
    typedef logic [4:0] brush_size_t;

    // Colours, 3 bits per channel as rrr_ggg_bbb
    localparam color_t COLOR_BACKGROUND = 9'b111_111_111;
    localparam color_t COLOR_ERASE      = 9'b111_111_111;

    // Brush size FSM, each size has a matching wait-for-release state
    typedef enum logic [2:0] {
        size_1,
        wait_1,
        size_3,
        wait_3,
        size_7,
        wait_7,
        size_20,
        wait_20
    } size_state_t;

    // Square stamp walker
    typedef enum logic [1:0] {
        stamp_idle,
        stamp_run,
        stamp_done
    } stamp_state_t;

    // Full screen clear sweep
    typedef enum logic [1:0] {
        clear_idle,
        clear_run,
        clear_done
    } clear_state_t;

endpackage

// File: hdl/cursor_tracker.sv
`timescale 1ns/1ps

module cursor_tracker (
    input  logic                   CLOCK_50,
    input  logic                   reset,
    input  logic                   mouse_valid,
    input  paint_pkg::mouse_delta_t mouse_dx,
    input  paint_pkg::mouse_delta_t mouse_dy,
    output paint_pkg::coord_x_t    cursor_x,
    output paint_pkg::coord_y_t    cursor_y
);

    logic       valid_q;
    logic       neg_x;
    logic       neg_y;
    logic [7:0] mag_x;
    logic [7:0] mag_y;
    logic [9:0] sum_x;
    logic [8:0] sum_y;

    // First stage splits each delta into sign and magnitude
    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= mouse_valid;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        neg_x <= mouse_dx[7];
        neg_y <= mouse_dy[7];
        mag_x <= mouse_dx[7] ? 8'(-mouse_dx) : mouse_dx;
        mag_y <= mouse_dy[7] ? 8'(-mouse_dy) : mouse_dy;
    end

    // Widened sums so the far edge check cannot overflow
    assign sum_x = {1'b0, cursor_x} + {2'b00, mag_x};
    assign sum_y = {1'b0, cursor_y} + {1'b0, mag_y};

    // Second stage moves the cursor and clamps on both edges
    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            cursor_x <= paint_pkg::coord_x_t'(paint_pkg::SCREEN_WIDTH / 2);
            cursor_y <= paint_pkg::coord_y_t'(paint_pkg::SCREEN_HEIGHT / 2);
        end else if (valid_q) begin
            if (!neg_x) begin
                cursor_x <= (sum_x < 10'(paint_pkg::SCREEN_WIDTH)) ? sum_x[8:0]
                          : paint_pkg::coord_x_t'(paint_pkg::SCREEN_WIDTH - 1);
            end else begin
                cursor_x <= (cursor_x >= {1'b0, mag_x}) ? cursor_x - {1'b0, mag_x} : '0;
            end
            // Screen y grows downward, so a positive dy decrements it
            if (!neg_y) begin
                cursor_y <= (cursor_y >= mag_y) ? cursor_y - mag_y : '0;
            end else begin
                cursor_y <= (sum_y < 9'(paint_pkg::SCREEN_HEIGHT)) ? sum_y[7:0]
                          : paint_pkg::coord_y_t'(paint_pkg::SCREEN_HEIGHT - 1);
            end
        end
    end

    a_cursor_on_screen: assert property (@(posedge CLOCK_50) disable iff (reset)
        (cursor_x < 9'(paint_pkg::SCREEN_WIDTH)) && (cursor_y < 8'(paint_pkg::SCREEN_HEIGHT)));

endmodule

// File: hdl/brush_size_select.sv
`timescale 1ns/1ps

module brush_size_select (
    input  logic                   CLOCK_50,
    input  logic                   reset,
    input  logic                   size_key_n,
    output paint_pkg::brush_size_t brush_size,
    output paint_pkg::brush_size_t brush_offset
);

    paint_pkg::size_state_t state;
    paint_pkg::size_state_t state_next;

    // Key is active low, size states wait for the press and wait states for the release
    always_comb begin
        state_next = state;
        case (state)
            paint_pkg::size_1:  if (!size_key_n) state_next = paint_pkg::wait_1;
            paint_pkg::wait_1:  if (size_key_n)  state_next = paint_pkg::size_3;
            paint_pkg::size_3:  if (!size_key_n) state_next = paint_pkg::wait_3;
            paint_pkg::wait_3:  if (size_key_n)  state_next = paint_pkg::size_7;
            paint_pkg::size_7:  if (!size_key_n) state_next = paint_pkg::wait_7;
            paint_pkg::wait_7:  if (size_key_n)  state_next = paint_pkg::size_20;
            paint_pkg::size_20: if (!size_key_n) state_next = paint_pkg::wait_20;
            paint_pkg::wait_20: if (size_key_n)  state_next = paint_pkg::size_1;
            default:            state_next = paint_pkg::size_1;
        endcase
    end

    // Offset is half the side, rounded down
    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            state        <= paint_pkg::size_1;
            brush_size   <= 5'd1;
            brush_offset <= 5'd0;
        end else begin
            state <= state_next;
            case (state)
                paint_pkg::size_1: begin
                    brush_size   <= 5'd1;
                    brush_offset <= 5'd0;
                end
                paint_pkg::size_3: begin
                    brush_size   <= 5'd3;
                    brush_offset <= 5'd1;
                end
                paint_pkg::size_7: begin
                    brush_size   <= 5'd7;
                    brush_offset <= 5'd3;
                end
                paint_pkg::size_20: begin
                    brush_size   <= 5'd20;
                    brush_offset <= 5'd10;
                end
                default: ;  // wait states keep the current size
            endcase
        end
    end

endmodule

// File: hdl/brush_stamper.sv
`timescale 1ns/1ps

module brush_stamper (
    input  logic                   CLOCK_50,
    input  logic                   reset,
    input  logic                   draw_enable,
    input  logic                   mouse_left,
    input  logic                   mouse_right,
    input  logic                   canvas_locked,
    input  paint_pkg::coord_x_t    cursor_x,
    input  paint_pkg::coord_y_t    cursor_y,
    input  paint_pkg::brush_size_t brush_size,
    input  paint_pkg::brush_size_t brush_offset,
    input  logic [2:0]             pen_sw,
    output paint_pkg::coord_x_t    stamp_x,
    output paint_pkg::coord_y_t    stamp_y,
    output paint_pkg::color_t      stamp_color,
    output logic                   stamp_req,
    output logic                   stamp_busy
);

    paint_pkg::stamp_state_t state;
    paint_pkg::brush_size_t  size_q;
    paint_pkg::brush_size_t  col;
    paint_pkg::brush_size_t  row;
    paint_pkg::color_t       pen_color;
    logic signed [10:0]      org_x;
    logic signed [10:0]      org_y;
    logic signed [10:0]      pos_x;
    logic signed [10:0]      pos_y;
    logic                    start;
    logic                    on_screen;
    logic                    last_col;
    logic                    last_row;

    assign start = draw_enable && (mouse_left || mouse_right) && !canvas_locked;
    assign pen_color = {{3{pen_sw[2]}}, {3{pen_sw[1]}}, {3{pen_sw[0]}}};

    // Current brush pixel can land off screen near an edge
    assign pos_x = org_x + $signed({6'b0, col});
    assign pos_y = org_y + $signed({6'b0, row});
    assign on_screen = !pos_x[10] && (pos_x < 11'sd320) && !pos_y[10] && (pos_y < 11'sd240);

    assign last_col = (col == size_q - 5'd1);
    assign last_row = (row == size_q - 5'd1);

    assign stamp_req  = (state == paint_pkg::stamp_run) && on_screen;
    assign stamp_x    = pos_x[8:0];
    assign stamp_y    = pos_y[7:0];
    assign stamp_busy = (state != paint_pkg::stamp_idle);

    // Origin, colour and size are frozen for the whole stamp
    always_ff @(posedge CLOCK_50) begin
        if (start && (state != paint_pkg::stamp_run)) begin
            org_x       <= $signed({2'b00, cursor_x}) - $signed({6'b0, brush_offset});
            org_y       <= $signed({3'b000, cursor_y}) - $signed({6'b0, brush_offset});
            size_q      <= brush_size;
            stamp_color <= mouse_left ? pen_color : paint_pkg::COLOR_ERASE;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            state <= paint_pkg::stamp_idle;
            col   <= '0;
            row   <= '0;
        end else begin
            case (state)
                paint_pkg::stamp_idle, paint_pkg::stamp_done: begin
                    col   <= '0;
                    row   <= '0;
                    state <= start ? paint_pkg::stamp_run : paint_pkg::stamp_idle;
                end
                paint_pkg::stamp_run: begin
                    // Row-major walk with the column index moving fastest
                    if (last_col) begin
                        col <= '0;
                        if (last_row) begin
                            state <= paint_pkg::stamp_done;
                        end else begin
                            row <= row + 5'd1;
                        end
                    end else begin
                        col <= col + 5'd1;
                    end
                end
                default: state <= paint_pkg::stamp_idle;
            endcase
        end
    end

    a_req_in_brush: assert property (@(posedge CLOCK_50) disable iff (reset)
        stamp_req |-> (col < size_q) && (row < size_q));

endmodule

// File: hdl/frame_writer.sv
`timescale 1ns/1ps

module frame_writer (
    input  logic                CLOCK_50,
    input  logic                reset,
    input  logic                clear_key_n,
    input  logic                mouse_left,
    input  logic                stamp_req,
    input  logic                stamp_busy,
    input  paint_pkg::coord_x_t stamp_x,
    input  paint_pkg::coord_y_t stamp_y,
    input  paint_pkg::color_t   stamp_color,
    output logic                canvas_locked,
    output paint_pkg::coord_x_t pixel_x,
    output paint_pkg::coord_y_t pixel_y,
    output paint_pkg::color_t   pixel_color,
    output logic                pixel_write
);

    paint_pkg::clear_state_t clear_state;
    paint_pkg::coord_x_t     sweep_x;
    paint_pkg::coord_y_t     sweep_y;
    logic                    title_mode;
    logic                    clear_pending;
    logic                    prev_clear_key_n;
    logic                    prev_left;
    logic                    clear_released;
    logic                    left_clicked;
    logic                    sweeping;

    assign clear_released = clear_key_n && !prev_clear_key_n;
    assign left_clicked   = mouse_left && !prev_left;
    assign sweeping       = (clear_state == paint_pkg::clear_run);

    // A pending clear also holds off new stamps so the sweep can start
    assign canvas_locked = title_mode || clear_pending || (clear_state != paint_pkg::clear_idle);

    // Edge history starts inactive so a button held through reset is no click
    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            prev_clear_key_n <= 1'b1;
            prev_left        <= 1'b1;
        end else begin
            prev_clear_key_n <= clear_key_n;
            prev_left        <= mouse_left;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            clear_state   <= paint_pkg::clear_idle;
            clear_pending <= 1'b0;
            title_mode    <= 1'b1;
            sweep_x       <= '0;
            sweep_y       <= '0;
        end else begin
            if (clear_released || (title_mode && left_clicked)) begin
                clear_pending <= 1'b1;
            end
            case (clear_state)
                paint_pkg::clear_idle: begin
                    // Wait for any stamp in flight to drain
                    if (clear_pending && !stamp_busy) begin
                        clear_pending <= 1'b0;
                        sweep_x       <= '0;
                        sweep_y       <= '0;
                        clear_state   <= paint_pkg::clear_run;
                    end
                end
                paint_pkg::clear_run: begin
                    if (sweep_x == 9'(paint_pkg::SCREEN_WIDTH - 1)) begin
                        sweep_x <= '0;
                        if (sweep_y == 8'(paint_pkg::SCREEN_HEIGHT - 1)) begin
                            clear_state <= paint_pkg::clear_done;
                        end else begin
                            sweep_y <= sweep_y + 8'd1;
                        end
                    end else begin
                        sweep_x <= sweep_x + 9'd1;
                    end
                end
                paint_pkg::clear_done: begin
                    title_mode  <= 1'b0;
                    clear_state <= paint_pkg::clear_idle;
                end
                default: clear_state <= paint_pkg::clear_idle;
            endcase
        end
    end

    // Registered write port where the sweep has priority over the stamper
    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            pixel_write <= 1'b0;
        end else begin
            pixel_write <= sweeping || stamp_req;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (sweeping) begin
            pixel_x     <= sweep_x;
            pixel_y     <= sweep_y;
            pixel_color <= paint_pkg::COLOR_BACKGROUND;
        end else begin
            pixel_x     <= stamp_x;
            pixel_y     <= stamp_y;
            pixel_color <= stamp_color;
        end
    end

    a_no_stamp_in_sweep: assert property (@(posedge CLOCK_50) disable iff (reset)
        stamp_req |-> !sweeping);

    a_sweep_stamp_idle: assert property (@(posedge CLOCK_50) disable iff (reset)
        (clear_state != paint_pkg::clear_idle) |-> !stamp_busy);

endmodule

// File: hdl/paint_top.sv
`timescale 1ns/1ps

module paint_top (
    input  logic                    CLOCK_50,
    input  logic                    reset,
    input  paint_pkg::mouse_delta_t mouse_dx,
    input  paint_pkg::mouse_delta_t mouse_dy,
    input  logic                    mouse_valid,
    input  logic                    mouse_left,
    input  logic                    mouse_right,
    input  logic                    draw_enable,
    input  logic [2:0]              pen_sw,
    input  logic                    size_key_n,
    input  logic                    clear_key_n,
    output paint_pkg::coord_x_t     pixel_x,
    output paint_pkg::coord_y_t     pixel_y,
    output paint_pkg::color_t       pixel_color,
    output logic                    pixel_write
);

    paint_pkg::coord_x_t    cursor_x;
    paint_pkg::coord_y_t    cursor_y;
    paint_pkg::brush_size_t brush_size;
    paint_pkg::brush_size_t brush_offset;
    paint_pkg::coord_x_t    stamp_x;
    paint_pkg::coord_y_t    stamp_y;
    paint_pkg::color_t      stamp_color;
    logic                   stamp_req;
    logic                   stamp_busy;
    logic                   canvas_locked;

    // Decode, mouse and key inputs
    cursor_tracker u_cursor (
        .CLOCK_50    (CLOCK_50),
        .reset       (reset),
        .mouse_valid (mouse_valid),
        .mouse_dx    (mouse_dx),
        .mouse_dy    (mouse_dy),
        .cursor_x    (cursor_x),
        .cursor_y    (cursor_y)
    );

    brush_size_select u_size (
        .CLOCK_50     (CLOCK_50),
        .reset        (reset),
        .size_key_n   (size_key_n),
        .brush_size   (brush_size),
        .brush_offset (brush_offset)
    );

    // Execute, brush stamping
    brush_stamper u_stamper (
        .CLOCK_50      (CLOCK_50),
        .reset         (reset),
        .draw_enable   (draw_enable),
        .mouse_left    (mouse_left),
        .mouse_right   (mouse_right),
        .canvas_locked (canvas_locked),
        .cursor_x      (cursor_x),
        .cursor_y      (cursor_y),
        .brush_size    (brush_size),
        .brush_offset  (brush_offset),
        .pen_sw        (pen_sw),
        .stamp_x       (stamp_x),
        .stamp_y       (stamp_y),
        .stamp_color   (stamp_color),
        .stamp_req     (stamp_req),
        .stamp_busy    (stamp_busy)
    );

    // Result, clear sweep and write port
    frame_writer u_writer (
        .CLOCK_50      (CLOCK_50),
        .reset         (reset),
        .clear_key_n   (clear_key_n),
        .mouse_left    (mouse_left),
        .stamp_req     (stamp_req),
        .stamp_busy    (stamp_busy),
        .stamp_x       (stamp_x),
        .stamp_y       (stamp_y),
        .stamp_color   (stamp_color),
        .canvas_locked (canvas_locked),
        .pixel_x       (pixel_x),
        .pixel_y       (pixel_y),
        .pixel_color   (pixel_color),
        .pixel_write   (pixel_write)
    );

endmodule

// File: dv/paint_tb.sv
`timescale 1ns/1ps

module paint_tb;

    typedef struct packed {
        paint_pkg::mouse_delta_t dx;
        paint_pkg::mouse_delta_t dy;
        logic [1:0]              button;
        logic [2:0]              pen;
        logic                    draw;
        logic [1:0]              presses;
        paint_pkg::brush_size_t  size;
    } table_row_t;

    typedef struct packed {
        paint_pkg::coord_x_t x;
        paint_pkg::coord_y_t y;
        paint_pkg::color_t   color;
    } pixel_entry_t;

    logic                    CLOCK_50;
    logic                    reset;
    paint_pkg::mouse_delta_t mouse_dx;
    paint_pkg::mouse_delta_t mouse_dy;
    logic                    mouse_valid;
    logic                    mouse_left;
    logic                    mouse_right;
    logic                    draw_enable;
    logic [2:0]              pen_sw;
    logic                    size_key_n;
    logic                    clear_key_n;
    paint_pkg::coord_x_t     pixel_x;
    paint_pkg::coord_y_t     pixel_y;
    paint_pkg::color_t       pixel_color;
    logic                    pixel_write;

    table_row_t        rows[$];
    pixel_entry_t      written[int];
    int                write_total;
    logic              order_check;
    int                model_x;
    int                model_y;

    paint_top UUT (
        .CLOCK_50    (CLOCK_50),
        .reset       (reset),
        .mouse_dx    (mouse_dx),
        .mouse_dy    (mouse_dy),
        .mouse_valid (mouse_valid),
        .mouse_left  (mouse_left),
        .mouse_right (mouse_right),
        .draw_enable (draw_enable),
        .pen_sw      (pen_sw),
        .size_key_n  (size_key_n),
        .clear_key_n (clear_key_n),
        .pixel_x     (pixel_x),
        .pixel_y     (pixel_y),
        .pixel_color (pixel_color),
        .pixel_write (pixel_write)
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever #10 CLOCK_50 = ~CLOCK_50;
    end

    task automatic fail_now(input string reason);
        $display("%s", reason);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_pixel(
        input paint_pkg::coord_x_t got_x,
        input paint_pkg::coord_y_t got_y,
        input paint_pkg::color_t   got_color,
        input paint_pkg::coord_x_t exp_x,
        input paint_pkg::coord_y_t exp_y,
        input paint_pkg::color_t   exp_color
    );
        if (got_x !== exp_x) begin
            fail_now($sformatf("Fail at %0t: pixel_x got %0d expected %0d", $time, got_x, exp_x));
        end
        if (got_y !== exp_y) begin
            fail_now($sformatf("Fail at %0t: pixel_y got %0d expected %0d", $time, got_y, exp_y));
        end
        if (got_color !== exp_color) begin
            fail_now($sformatf("Fail at %0t: pixel_color got %h expected %h",
                               $time, got_color, exp_color));
        end
    endtask

    task automatic check_count(input int got, input int expected, input string name);
        if (got != expected) begin
            fail_now($sformatf("Fail at %0t: %s got %0d expected %0d", $time, name, got, expected));
        end
    endtask

    // Every write lands in the set and the sweep is also checked for order
    always @(negedge CLOCK_50) begin
        if (!reset && pixel_write === 1'b1) begin
            if (order_check) begin
                check_pixel(pixel_x, pixel_y, pixel_color,
                            paint_pkg::coord_x_t'(write_total % paint_pkg::SCREEN_WIDTH),
                            paint_pkg::coord_y_t'(write_total / paint_pkg::SCREEN_WIDTH),
                            paint_pkg::COLOR_BACKGROUND);
            end
            written[int'(pixel_y) * paint_pkg::SCREEN_WIDTH + int'(pixel_x)] =
                {pixel_x, pixel_y, pixel_color};
            write_total++;
        end
    end

    function automatic int clamp_coord(input int value, input int max_value);
        if (value < 0) begin
            return 0;
        end
        if (value > max_value) begin
            return max_value;
        end
        return value;
    endfunction

    task automatic add_row(input int dx, input int dy, input int button, input int pen,
                           input int draw, input int presses, input int size);
        table_row_t r;
        r.dx      = paint_pkg::mouse_delta_t'(dx);
        r.dy      = paint_pkg::mouse_delta_t'(dy);
        r.button  = 2'(button);
        r.pen     = 3'(pen);
        r.draw    = (draw != 0);
        r.presses = 2'(presses);
        r.size    = paint_pkg::brush_size_t'(size);
        rows.push_back(r);
    endtask

    // Button 1 is left and 2 is right
    task automatic build_table();
        add_row(0, 0, 1, 4, 1, 0, 1);
        add_row(127, 0, 1, 2, 1, 0, 1);
        add_row(127, 127, 2, 0, 1, 0, 1);
        add_row(-128, -128, 1, 1, 1, 0, 1);
        add_row(-128, -128, 2, 0, 1, 0, 1);
        add_row(-128, 0, 1, 7, 1, 0, 1);
        add_row(100, 100, 1, int'($urandom % 8), 1, 1, 3);
        add_row(int'($urandom % 256) - 128, int'($urandom % 256) - 128, 1,
                int'($urandom % 8), 1, 1, 7);
        add_row(60, 19, 2, 0, 1, 1, 20);
        add_row(-128, -128, 1, int'($urandom % 8), 0, 0, 20);
        add_row(-128, -128, 0, 0, 1, 0, 20);
        // Bottom left corner with the largest brush
        add_row(-128, -128, 1, int'($urandom % 8), 1, 0, 20);
        add_row(127, 127, 1, int'($urandom % 8), 1, 1, 1);
        add_row(int'($urandom % 256) - 128, int'($urandom % 256) - 128, 2, 0, 1, 2, 7);
        add_row(127, 127, 1, int'($urandom % 8), 1, 0, 7);
    endtask

    task automatic move_mouse(input paint_pkg::mouse_delta_t dx,
                              input paint_pkg::mouse_delta_t dy);
        @(posedge CLOCK_50);
        mouse_dx    <= dx;
        mouse_dy    <= dy;
        mouse_valid <= 1'b1;
        @(posedge CLOCK_50);
        mouse_valid <= 1'b0;
        repeat (3) @(posedge CLOCK_50);
        // Positive dy moves up the screen
        model_x = clamp_coord(model_x + int'($signed(dx)), paint_pkg::SCREEN_WIDTH - 1);
        model_y = clamp_coord(model_y - int'($signed(dy)), paint_pkg::SCREEN_HEIGHT - 1);
    endtask

    task automatic press_size_key(input int presses);
        repeat (presses) begin
            @(posedge CLOCK_50);
            size_key_n <= 1'b0;
            @(posedge CLOCK_50);
            size_key_n <= 1'b1;
        end
        repeat (3) @(posedge CLOCK_50);
    endtask

    // Held until the first write so a stamp still in flight cannot swallow the press
    task automatic hold_buttons(input logic left, input logic right, input logic until_write);
        int cycles;
        cycles = 0;
        @(posedge CLOCK_50);
        mouse_left  <= left;
        mouse_right <= right;
        if (until_write) begin
            while (write_total == 0) begin
                @(posedge CLOCK_50);
                cycles++;
                if (cycles > 1000) begin
                    fail_now("Timeout waiting for the first write of a stamp");
                end
            end
        end else begin
            repeat (10) @(posedge CLOCK_50);
        end
        mouse_left  <= 1'b0;
        mouse_right <= 1'b0;
    endtask

    task automatic wait_quiet(input int limit);
        int quiet;
        int cycles;
        quiet  = 0;
        cycles = 0;
        while (quiet < 50) begin
            @(negedge CLOCK_50);
            cycles++;
            if (cycles > limit) begin
                fail_now("Timeout waiting for pixel_write to stay low for 50 cycles");
            end
            if (pixel_write) begin
                quiet = 0;
            end else begin
                quiet++;
            end
        end
    endtask

    task automatic check_square(input int cx, input int cy, input int size,
                                input paint_pkg::color_t color);
        int x;
        int y;
        int key;
        int expected;
        expected = 0;
        for (y = cy - size / 2; y < cy - size / 2 + size; y++) begin
            for (x = cx - size / 2; x < cx - size / 2 + size; x++) begin
                if (x >= 0 && x < paint_pkg::SCREEN_WIDTH
                        && y >= 0 && y < paint_pkg::SCREEN_HEIGHT) begin
                    expected++;
                    key = y * paint_pkg::SCREEN_WIDTH + x;
                    if (!written.exists(key)) begin
                        fail_now($sformatf("No write seen for brush pixel (%0d, %0d)", x, y));
                    end
                    check_pixel(written[key].x, written[key].y, written[key].color,
                                paint_pkg::coord_x_t'(x), paint_pkg::coord_y_t'(y), color);
                end
            end
        end
        check_count(written.num(), expected, "brush pixel count");
    endtask

    task automatic apply_row(input table_row_t row);
        paint_pkg::color_t color;
        logic              drawing;
        written.delete();
        write_total = 0;
        move_mouse(row.dx, row.dy);
        press_size_key(int'(row.presses));
        @(posedge CLOCK_50);
        draw_enable <= row.draw;
        pen_sw      <= row.pen;
        drawing = row.draw && (row.button != 2'b00);
        hold_buttons(row.button[0], row.button[1], drawing);
        wait_quiet(2000);
        if (drawing) begin
            // Left paints with the pen and right erases
            if (row.button[0]) begin
                color[8:6] = row.pen[2] ? 3'b111 : 3'b000;
                color[5:3] = row.pen[1] ? 3'b111 : 3'b000;
                color[2:0] = row.pen[0] ? 3'b111 : 3'b000;
            end else begin
                color = paint_pkg::COLOR_ERASE;
            end
            check_square(model_x, model_y, int'(row.size), color);
        end else begin
            check_count(write_total, 0, "writes with drawing off");
        end
    endtask

    task automatic check_sweep(input int limit);
        wait_quiet(limit);
        check_count(write_total, paint_pkg::SCREEN_WIDTH * paint_pkg::SCREEN_HEIGHT,
                    "sweep writes");
        order_check = 1'b0;
    endtask

    initial begin
        void'($urandom(10));
        reset       = 1'b1;
        mouse_dx    = '0;
        mouse_dy    = '0;
        mouse_valid = 1'b0;
        mouse_left  = 1'b0;
        mouse_right = 1'b0;
        draw_enable = 1'b0;
        pen_sw      = 3'b000;
        size_key_n  = 1'b1;
        clear_key_n = 1'b1;
        order_check = 1'b0;
        write_total = 0;
        model_x     = paint_pkg::SCREEN_WIDTH / 2;
        model_y     = paint_pkg::SCREEN_HEIGHT / 2;
        build_table();
        repeat (5) @(posedge CLOCK_50);
        reset <= 1'b0;

        // Title mode blocks drawing until a left click
        @(posedge CLOCK_50);
        draw_enable <= 1'b1;
        hold_buttons(1'b0, 1'b1, 1'b0);
        wait_quiet(1000);
        check_count(write_total, 0, "writes in title mode");
        order_check = 1'b1;
        @(posedge CLOCK_50);
        mouse_left <= 1'b1;
        @(posedge CLOCK_50);
        mouse_left <= 1'b0;
        check_sweep(100000);

        foreach (rows[i]) begin
            apply_row(rows[i]);
        end

        // Clear key press and release
        written.delete();
        write_total = 0;
        order_check = 1'b1;
        @(posedge CLOCK_50);
        clear_key_n <= 1'b0;
        repeat (3) @(posedge CLOCK_50);
        clear_key_n <= 1'b1;
        check_sweep(100000);

        $display("sim passed");
        $finish;
    end

endmodule

// File: sources.f
hdl/paint_pkg.sv
hdl/cursor_tracker.sv
hdl/brush_size_select.sv
hdl/brush_stamper.sv
hdl/frame_writer.sv
hdl/paint_top.sv
dv/paint_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the paint core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module paint_tb -o Vpaint_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build returned status $status"
    exit $status
fi

./obj_dir/Vpaint_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation returned status $status"
    exit $status
fi

exit 0
